// ==== all.f ====
+incdir+include
rtl/kdi_pkg.sv
rtl/kdi_req_arbiter.sv
rtl/kdi_key_regs.sv
rtl/kdi_ctrl_fsm.sv
rtl/kdi_top.sv
bench/kdi_asserts.sv
bench/kdi_tb.sv

// ==== bench/kdi_asserts.sv ====
//////////////////////////////
// Concurrent assertions on handshakes and error rules
//////////////////////////////

`timescale 1ns/1ps

module kdi_asserts (
  input logic                 clk_i,
  input logic                 rst_ni,
  input kdi_pkg::req_vec_t    req_i,
  input kdi_pkg::req_vec_t    ack_o,
  input logic                 fsm_err_o,
  input logic                 edn_req_o,
  input logic                 edn_ack_i,
  input logic                 scrmbl_mtx_req_o,
  input logic                 scrmbl_mtx_gnt_i,
  input kdi_pkg::scrmbl_cmd_e scrmbl_cmd_o,
  input kdi_pkg::block_t      scrmbl_data_o,
  input logic                 scrmbl_valid_o,
  input logic                 scrmbl_ready_i
);

  // Failures seen, read back by the testbench
  int assert_errs = 0;

  // Ack only to a pending requester, for one cycle
  a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_o != '0) |-> ((ack_o & ~req_i) == '0) ##1 (ack_o == '0))
    else begin
      $error("ack_o given to an idle requester or held for more than one cycle");
      assert_errs++;
    end

  // Command and data held while the datapath stalls
  a_cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_ni || fsm_err_o)
    (scrmbl_valid_o && !scrmbl_ready_i) |=>
      (scrmbl_valid_o && $stable(scrmbl_cmd_o) && $stable(scrmbl_data_o)))
    else begin
      $error("datapath command changed before ready");
      assert_errs++;
    end

  // No datapath command without the mutex
  a_mtx_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    scrmbl_valid_o |-> (scrmbl_mtx_req_o && scrmbl_mtx_gnt_i))
    else begin
      $error("datapath command issued without the mutex");
      assert_errs++;
    end

  // Entropy request stays up until acked
  a_edn_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (edn_req_o && !edn_ack_i) |=> edn_req_o)
    else begin
      $error("edn_req_o dropped before edn_ack_i");
      assert_errs++;
    end

  // Error state is terminal and quiet
  a_err_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fsm_err_o |=> (fsm_err_o && !scrmbl_valid_o && !scrmbl_mtx_req_o && ack_o == '0))
    else begin
      $error("error state left or still active");
      assert_errs++;
    end

endmodule

// ==== bench/kdi_tb.sv ====
//////////////////////////////
// Testbench with datapath, mutex and entropy models
//////////////////////////////

`timescale 1ns/1ps
`include "kdi_params.svh"

module kdi_tb;
  import kdi_pkg::*;

  localparam int NumRows       = 6;
  // 400 cycles per row plus reset and the idle check
  localparam int TimeoutCycles = NumRows * 400 + 100;

  logic                        clk_i, rst_ni, kdi_en_i, escalate_en_i;
  req_vec_t                    req_i, ack_o;
  logic                        seed_valid_i, seed_valid_o, fsm_err_o;
  seed_t                       flash_data_seed_i, flash_addr_seed_i;
  logic [`KDI_SRAM_SEED_W-1:0] sram_seed_i;
  logic                        edn_req_o, edn_ack_i;
  block_t                      edn_data_i, scrmbl_data_o, scrmbl_data_i;
  key_t                        key_o;
  nonce_t                      nonce_o;
  logic                        scrmbl_mtx_req_o, scrmbl_mtx_gnt_i;
  scrmbl_cmd_e                 scrmbl_cmd_o;
  digest_sel_e                 scrmbl_sel_o;
  logic                        scrmbl_valid_o, scrmbl_ready_i, scrmbl_valid_i;

  // Stimulus table, one row per case
  req_vec_t                    row_mask      [NumRows];
  logic                        row_sv        [NumRows];
  logic                        row_esc       [NumRows];
  seed_t                       row_data_seed [NumRows];
  seed_t                       row_addr_seed [NumRows];
  logic [`KDI_SRAM_SEED_W-1:0] row_sram_seed [NumRows];

  // Model and scoreboard state
  int          cycle_cnt = 0;
  int          err_cnt = 0;
  int          chk_cnt = 0;
  int          gnt_wait, dp_wait, edn_wait, rr_ptr;
  block_t      dp_acc, dp_res;
  scrmbl_cmd_e prev_cmd;
  logic [31:0] edn_seq;
  block_t      edn_words [$];
  key_t        exp_key;
  nonce_t      exp_nonce;
  logic        exp_sv;

  kdi_top UUT (.*);

  bind kdi_top kdi_asserts u_asserts (
    .clk_i, .rst_ni, .req_i, .ack_o, .fsm_err_o, .edn_req_o, .edn_ack_i, .scrmbl_mtx_req_o,
    .scrmbl_mtx_gnt_i, .scrmbl_cmd_o, .scrmbl_data_o, .scrmbl_valid_o, .scrmbl_ready_i
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Watchdog
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////
  // Mutex, datapath and entropy models
  //////////////////////////////

  always @(posedge clk_i) begin : p_models
    block_t word;
    // Grant 0 to 3 cycles after the request
    if (!scrmbl_mtx_req_o) begin
      scrmbl_mtx_gnt_i <= 1'b0;
      gnt_wait = $urandom_range(0, 3);
    end else if (gnt_wait == 0) begin
      scrmbl_mtx_gnt_i <= 1'b1;
    end else begin
      gnt_wait--;
    end
    // Result pulse 1 to 4 cycles after DigestFinalize
    scrmbl_valid_i <= 1'b0;
    if (dp_wait > 0) begin
      dp_wait--;
      if (dp_wait == 0) begin
        scrmbl_valid_i <= 1'b1;
        scrmbl_data_i  <= dp_res;
      end
    end
    scrmbl_ready_i <= ($urandom_range(0, 3) != 0);
    if (scrmbl_valid_o && scrmbl_ready_i) begin
      case (scrmbl_cmd_o)
        DigestInit: dp_acc = '0;
        DigestFinalize: begin
          if (prev_cmd != Digest) begin
            report_failure("DigestFinalize issued without a preceding Digest");
          end
          dp_res  = dp_acc ^ block_t'(scrmbl_sel_o);
          dp_wait = $urandom_range(1, 4);
        end
        // LoadShadow opens a block pair and Digest closes it
        default: begin
          check_val("scrmbl_cmd_o", scrmbl_cmd_o,
                    (prev_cmd == LoadShadow) ? Digest : LoadShadow);
          dp_acc = dp_acc ^ scrmbl_data_o;
        end
      endcase
      prev_cmd = scrmbl_cmd_o;
    end
    // Entropy ack 1 to 3 cycles after the request
    edn_ack_i <= 1'b0;
    if (edn_wait > 0) begin
      edn_wait--;
      if (edn_wait == 0) begin
        word = {edn_seq ^ 32'hc3a5_0f1e, edn_seq * 32'h9e37_79b9};
        edn_seq++;
        edn_ack_i  <= 1'b1;
        edn_data_i <= word;
        // Kept for the prediction
        edn_words.push_back(word);
      end
    end else if (edn_req_o && !edn_ack_i) begin
      edn_wait = $urandom_range(1, 3);
    end
  end

  //////////////////////////////
  // Checks and prediction
  //////////////////////////////

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    err_cnt++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  function automatic seed_t random_seed();
    seed_t s;
    for (int i = 0; i < 8; i++) begin
      s[32*i +: 32] = $urandom;
    end
    return s;
  endfunction

  // Lowest pending index at or after the pointer
  function automatic int next_grant(input req_vec_t pend, input int ptr);
    int c;
    c = ptr;
    for (int i = 0; i < `KDI_NUM_REQ; i++) begin
      if (pend[c]) begin
        return c;
      end
      c = (c + 1) % `KDI_NUM_REQ;
    end
    return 0;
  endfunction

  // Expected key, nonce and seed valid after serving requester idx
  task automatic predict_response(input int idx);
    seed_t  s;
    block_t half, wa, wb;
    int     need;
    need = (idx == 2) ? 6 : (idx == 1) ? 1 : 2;
    if (edn_words.size() != need) begin
      report_failure($sformatf("requester %0d used %0d entropy words, expected %0d",
                               idx, edn_words.size(), need));
      return;
    end
    case (idx)
      0:       s = flash_data_seed_i;
      1:       s = flash_addr_seed_i;
      default: s = {sram_seed_i, sram_seed_i};
    endcase
    if (!seed_valid_i) begin
      s = '0;
    end
    for (int h = 0; h < 2; h++) begin
      half = s[128*h +: 64] ^ s[128*h+64 +: 64] ^ block_t'(idx);
      // SRAM halves fold in two words staged in the nonce register
      if (idx == 2) begin
        wa   = edn_words.pop_front();
        wb   = edn_words.pop_front();
        half = half ^ wa ^ wb;
      end
      exp_key[64*h +: 64] = half;
    end
    exp_sv = seed_valid_i;
    exp_nonce[63:0] = edn_words.pop_front();
    if (idx != 1) begin
      exp_nonce[127:64] = edn_words.pop_front();
    end
  endtask

  task automatic check_idle_outputs();
    check_val("ack_o", ack_o, '0);
    check_val("edn_req_o", edn_req_o, 1'b0);
    check_val("scrmbl_mtx_req_o", scrmbl_mtx_req_o, 1'b0);
    check_val("scrmbl_valid_o", scrmbl_valid_o, 1'b0);
    check_val("fsm_err_o", fsm_err_o, 1'b0);
    check_val("key_o", key_o, `KDI_KEY_INIT);
    check_val("nonce_o", nonce_o, `KDI_NONCE_INIT);
    check_val("seed_valid_o", seed_valid_o, 1'b0);
  endtask

  //////////////////////////////
  // Row sequencing
  //////////////////////////////

  task automatic apply_row(input int r);
    @(posedge clk_i);
    flash_data_seed_i <= row_data_seed[r];
    flash_addr_seed_i <= row_addr_seed[r];
    sram_seed_i       <= row_sram_seed[r];
    seed_valid_i      <= row_sv[r];
    req_i             <= req_i | row_mask[r];
  endtask

  // One ack per raised bit, in round-robin order
  task automatic serve_row(input int r);
    req_vec_t pend;
    int       idx;
    pend = row_mask[r];
    while (pend != '0) begin
      idx = next_grant(pend, rr_ptr);
      @(posedge clk_i);
      while (ack_o == '0) begin
        @(posedge clk_i);
      end
      check_val("ack_o", ack_o, 128'(1) << idx);
      predict_response(idx);
      check_val("key_o", key_o, exp_key);
      check_val("nonce_o", nonce_o, exp_nonce);
      check_val("seed_valid_o", seed_valid_o, exp_sv);
      // Requester drops its bit after the ack
      req_i  <= req_i & ~ack_o;
      pend   = pend & ~ack_o;
      rr_ptr = (idx + 1) % `KDI_NUM_REQ;
    end
  endtask

  task automatic escalate_mid_request();
    logic edn_dropped;
    edn_dropped = 1'b0;
    // Escalate while an entropy word is open
    @(posedge clk_i);
    while (!edn_req_o) begin
      @(posedge clk_i);
    end
    escalate_en_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    escalate_en_i <= 1'b0;
    for (int i = 0; i < 40; i++) begin
      check_val("fsm_err_o", fsm_err_o, 1'b1);
      check_val("ack_o", ack_o, '0);
      check_val("scrmbl_mtx_req_o", scrmbl_mtx_req_o, 1'b0);
      check_val("scrmbl_valid_o", scrmbl_valid_o, 1'b0);
      if (!edn_req_o) begin
        edn_dropped = 1'b1;
      end else if (edn_dropped) begin
        report_failure("edn_req_o raised again after escalation");
      end
      @(posedge clk_i);
    end
  endtask

  initial begin : p_main
    int seed_dummy;
    int asrt_errs;
    seed_dummy = $urandom(32'h9b1b4ae4);
    rst_ni = 1'b0;
    kdi_en_i = 1'b0;
    escalate_en_i = 1'b0;
    req_i = '0;
    seed_valid_i = 1'b0;
    flash_data_seed_i = '0;
    flash_addr_seed_i = '0;
    sram_seed_i = '0;
    edn_ack_i = 1'b0;
    edn_data_i = '0;
    scrmbl_mtx_gnt_i = 1'b0;
    scrmbl_data_i = '0;
    scrmbl_ready_i = 1'b0;
    scrmbl_valid_i = 1'b0;
    gnt_wait = 0;
    dp_wait = 0;
    edn_wait = 0;
    edn_seq = 32'd1;
    rr_ptr = 0;
    dp_acc = '0;
    prev_cmd = DigestInit;
    exp_key = `KDI_KEY_INIT;
    exp_nonce = `KDI_NONCE_INIT;
    exp_sv = 1'b0;
    // Data key, invalid address key, SRAM key, data key, all three, escalation
    row_mask = '{3'b001, 3'b010, 3'b100, 3'b001, 3'b111, 3'b100};
    row_sv   = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};
    row_esc  = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    for (int r = 0; r < NumRows; r++) begin
      row_data_seed[r] = random_seed();
      row_addr_seed[r] = random_seed();
      row_sram_seed[r] = 128'(random_seed());
    end
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Pending request must wait for the enable pulse
    apply_row(0);
    for (int i = 0; i < 20; i++) begin
      @(posedge clk_i);
      check_idle_outputs();
    end
    kdi_en_i <= 1'b1;
    @(posedge clk_i);
    kdi_en_i <= 1'b0;
    for (int r = 0; r < NumRows; r++) begin
      if (r > 0) begin
        apply_row(r);
      end
      if (row_esc[r]) begin
        escalate_mid_request();
      end else begin
        serve_row(r);
      end
    end
    repeat (5) @(posedge clk_i);
    asrt_errs = UUT.u_asserts.assert_errs;
    err_cnt   = err_cnt + asrt_errs;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", chk_cnt, err_cnt, asrt_errs);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== include/kdi_params.svh ====
//////////////////////////////
// Widths, requester count and reset constants of the key derivation unit
//////////////////////////////

`ifndef KDI_PARAMS_SVH
`define KDI_PARAMS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// One digest block, also one entropy word
`define KDI_BLOCK_W 64

// Derived key, two digest blocks
`define KDI_KEY_W 128

// Flash seeds, four digest blocks
`define KDI_SEED_W 256

// SRAM seed, duplicated to a full seed inside the arbiter
`define KDI_SRAM_SEED_W 128

// Flash data, flash address and SRAM requesters
`define KDI_NUM_REQ 3

//////////////////////////////
// Output register values after reset
//////////////////////////////

`define KDI_KEY_INIT 128'h3a5c_96e1_0f47_b2d8_c61e_7a93_54bd_0e28
`define KDI_NONCE_INIT 128'h71d2_48af_e390_5c1b_9e06_b7f4_2a8d_63c5

`endif

// ==== rtl/kdi_ctrl_fsm.sv ====
//////////////////////////////
// Controller FSM for digest, entropy and nonce steps
//////////////////////////////

`timescale 1ns/1ps

module kdi_ctrl_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  kdi_en_i,
  input  logic                  escalate_en_i,
  input  logic                  req_valid_i,
  input  logic                  ingest_entropy_i,
  input  logic                  nonce_last_i,
  input  kdi_pkg::digest_sel_e  digest_sel_i,
  input  kdi_pkg::blk_cnt_t     seed_cnt_i,
  input  kdi_pkg::blk_cnt_t     ent_cnt_i,
  input  logic                  edn_ack_i,
  input  logic                  scrmbl_mtx_gnt_i,
  input  logic                  scrmbl_ready_i,
  input  logic                  scrmbl_valid_i,
  output logic                  seed_cnt_clr_o,
  output logic                  seed_cnt_en_o,
  output logic                  ent_cnt_clr_o,
  output logic                  ent_cnt_en_o,
  output logic                  key_wr_o,
  output logic                  nonce_wr_o,
  output logic                  seed_valid_wr_o,
  output logic                  data_sel_o,
  output logic                  req_done_o,
  output logic                  edn_req_o,
  output logic                  scrmbl_mtx_req_o,
  output kdi_pkg::scrmbl_cmd_e  scrmbl_cmd_o,
  output kdi_pkg::digest_sel_e  scrmbl_sel_o,
  output logic                  scrmbl_valid_o,
  output logic                  fsm_err_o
);
  import kdi_pkg::*;

  kdi_state_e state_d, state_q;
  logic       edn_req_d, edn_req_q;
  logic       edn_done;

  // Word accepted by the entropy source
  assign edn_done     = edn_req_q & edn_ack_i;
  assign edn_req_o    = edn_req_q;
  assign scrmbl_sel_o = digest_sel_i;

  always_comb begin : p_fsm
    state_d          = state_q;
    seed_cnt_clr_o   = 1'b0;
    seed_cnt_en_o    = 1'b0;
    ent_cnt_clr_o    = 1'b0;
    ent_cnt_en_o     = 1'b0;
    key_wr_o         = 1'b0;
    nonce_wr_o       = 1'b0;
    seed_valid_wr_o  = 1'b0;
    data_sel_o       = 1'b0;
    req_done_o       = 1'b0;
    scrmbl_mtx_req_o = 1'b0;
    scrmbl_cmd_o     = LoadShadow;
    scrmbl_valid_o   = 1'b0;
    fsm_err_o        = 1'b0;
    // An open entropy request stays up until acked
    edn_req_d        = edn_req_q & ~edn_ack_i;

    case (state_q)
      // Idle until the unit is enabled
      ResetSt: begin
        if (kdi_en_i) begin
          state_d = IdleSt;
        end
      end
      IdleSt: begin
        if (req_valid_i) begin
          state_d        = DigClrSt;
          seed_cnt_clr_o = 1'b1;
          ent_cnt_clr_o  = 1'b1;
        end
      end
      // Reset the digest once the mutex is held
      DigClrSt: begin
        scrmbl_mtx_req_o = 1'b1;
        scrmbl_cmd_o     = DigestInit;
        scrmbl_valid_o   = scrmbl_mtx_gnt_i;
        if (scrmbl_mtx_gnt_i && scrmbl_ready_i) begin
          state_d = DigLoadSt;
        end
      end
      // Even block with LoadShadow, odd block with Digest
      DigLoadSt: begin
        scrmbl_mtx_req_o = 1'b1;
        scrmbl_valid_o   = 1'b1;
        if (seed_cnt_i[0]) begin
          scrmbl_cmd_o = Digest;
          if (scrmbl_ready_i) begin
            state_d = ingest_entropy_i ? FetchEntropySt : DigFinSt;
          end
        end else if (scrmbl_ready_i) begin
          seed_cnt_en_o = 1'b1;
        end
      end
      // Two entropy words, request dropped for a cycle after each ack
      FetchEntropySt: begin
        scrmbl_mtx_req_o = 1'b1;
        edn_req_d        = ~edn_done;
        if (edn_done) begin
          nonce_wr_o = 1'b1;
          if (ent_cnt_i == 2'd1) begin
            state_d       = DigEntropySt;
            ent_cnt_clr_o = 1'b1;
          end else begin
            ent_cnt_en_o = 1'b1;
          end
        end
      end
      // Fold the entropy words into the digest
      DigEntropySt: begin
        scrmbl_mtx_req_o = 1'b1;
        scrmbl_valid_o   = 1'b1;
        data_sel_o       = 1'b1;
        if (ent_cnt_i[0]) begin
          scrmbl_cmd_o = Digest;
          if (scrmbl_ready_i) begin
            state_d       = DigFinSt;
            ent_cnt_clr_o = 1'b1;
          end
        end else if (scrmbl_ready_i) begin
          ent_cnt_en_o = 1'b1;
        end
      end
      DigFinSt: begin
        scrmbl_mtx_req_o = 1'b1;
        scrmbl_valid_o   = 1'b1;
        scrmbl_cmd_o     = DigestFinalize;
        if (scrmbl_ready_i) begin
          state_d = DigWaitSt;
        end
      end
      // Store the key half, then second half or nonce
      DigWaitSt: begin
        scrmbl_mtx_req_o = 1'b1;
        if (scrmbl_valid_i) begin
          key_wr_o = 1'b1;
          if (seed_cnt_i == 2'd1) begin
            seed_cnt_en_o = 1'b1;
            state_d       = DigClrSt;
          end else begin
            seed_cnt_clr_o  = 1'b1;
            seed_valid_wr_o = 1'b1;
            state_d         = FetchNonceSt;
          end
        end
      end
      // Nonce words 0 up to nonce_last, mutex released
      FetchNonceSt: begin
        edn_req_d = ~edn_done;
        if (edn_done) begin
          nonce_wr_o = 1'b1;
          if (ent_cnt_i == {1'b0, nonce_last_i}) begin
            state_d       = FinishSt;
            ent_cnt_clr_o = 1'b1;
            edn_req_d     = 1'b0;
          end else begin
            ent_cnt_en_o = 1'b1;
          end
        end
      end
      FinishSt: begin
        req_done_o = 1'b1;
        state_d    = IdleSt;
      end
      // Terminal
      ErrorSt: begin
        fsm_err_o = 1'b1;
      end
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation overrides everything, no new entropy request and no ack
    if (escalate_en_i) begin
      state_d         = ErrorSt;
      fsm_err_o       = 1'b1;
      edn_req_d       = edn_req_q & ~edn_ack_i;
      req_done_o      = 1'b0;
      key_wr_o        = 1'b0;
      nonce_wr_o      = 1'b0;
      seed_valid_wr_o = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q   <= ResetSt;
      edn_req_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      edn_req_q <= edn_req_d;
    end
  end

endmodule

// ==== rtl/kdi_key_regs.sv ====
//////////////////////////////
// Block counters, key, nonce and seed-valid registers, datapath block mux
//////////////////////////////

`timescale 1ns/1ps
`include "kdi_params.svh"

module kdi_key_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  kdi_pkg::seed_t     seed_i,
  input  logic               seed_valid_i,
  input  logic               seed_cnt_clr_i,
  input  logic               seed_cnt_en_i,
  input  logic               ent_cnt_clr_i,
  input  logic               ent_cnt_en_i,
  input  logic               key_wr_i,
  input  logic               nonce_wr_i,
  input  logic               seed_valid_wr_i,
  input  logic               data_sel_i,
  input  kdi_pkg::block_t    edn_data_i,
  input  kdi_pkg::block_t    scrmbl_data_i,
  output kdi_pkg::blk_cnt_t  seed_cnt_o,
  output kdi_pkg::blk_cnt_t  ent_cnt_o,
  output kdi_pkg::block_t    scrmbl_data_o,
  output kdi_pkg::key_t      key_o,
  output kdi_pkg::nonce_t    nonce_o,
  output logic               seed_valid_o
);
  import kdi_pkg::*;

  blk_cnt_t seed_cnt_q, ent_cnt_q;
  key_t     key_q;
  nonce_t   nonce_q;
  logic     seed_valid_q;
  block_t   seed_blk, ent_word;

  //////////////////////////////
  // Counters
  //////////////////////////////

  // Clear wins over increment
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      seed_cnt_q <= '0;
      ent_cnt_q  <= '0;
    end else begin
      if (seed_cnt_clr_i) begin
        seed_cnt_q <= '0;
      end else if (seed_cnt_en_i) begin
        seed_cnt_q <= seed_cnt_q + 2'd1;
      end
      if (ent_cnt_clr_i) begin
        ent_cnt_q <= '0;
      end else if (ent_cnt_en_i) begin
        ent_cnt_q <= ent_cnt_q + 2'd1;
      end
    end
  end

  //////////////////////////////
  // Output registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_out
    if (!rst_ni) begin
      key_q        <= `KDI_KEY_INIT;
      nonce_q      <= `KDI_NONCE_INIT;
      seed_valid_q <= 1'b0;
    end else begin
      // Key half 0 after blocks 0 and 1, half 1 after blocks 2 and 3
      if (key_wr_i) begin
        key_q[seed_cnt_q[1] * `KDI_BLOCK_W +: `KDI_BLOCK_W] <= scrmbl_data_i;
      end
      // Words not written keep their old value
      if (nonce_wr_i) begin
        nonce_q[ent_cnt_q[0] * `KDI_BLOCK_W +: `KDI_BLOCK_W] <= edn_data_i;
      end
      if (seed_valid_wr_i) begin
        seed_valid_q <= seed_valid_i;
      end
    end
  end

  //////////////////////////////
  // Datapath block mux
  //////////////////////////////

  // Entropy words are staged in the nonce register
  assign ent_word = nonce_q[ent_cnt_q[0] * `KDI_BLOCK_W +: `KDI_BLOCK_W];
  // Invalid seeds are gated to zero
  assign seed_blk = seed_valid_i ? seed_i[seed_cnt_q * `KDI_BLOCK_W +: `KDI_BLOCK_W] : '0;

  assign scrmbl_data_o = data_sel_i ? ent_word : seed_blk;

  assign seed_cnt_o   = seed_cnt_q;
  assign ent_cnt_o    = ent_cnt_q;
  assign key_o        = key_q;
  assign nonce_o      = nonce_q;
  assign seed_valid_o = seed_valid_q;

endmodule

// ==== rtl/kdi_pkg.sv ====
//////////////////////////////
// Shared types of the key derivation unit
//////////////////////////////

`include "kdi_params.svh"

package kdi_pkg;

  //////////////////////////////
  // Vector types
  //////////////////////////////

  typedef logic [`KDI_BLOCK_W-1:0] block_t;
  typedef logic [`KDI_KEY_W-1:0]   key_t;
  typedef logic [`KDI_SEED_W-1:0]  seed_t;
  // Two entropy words
  typedef logic [`KDI_KEY_W-1:0]   nonce_t;
  typedef logic [`KDI_NUM_REQ-1:0] req_vec_t;
  // Counts seed blocks and entropy words
  typedef logic [1:0]              blk_cnt_t;

  //////////////////////////////
  // Enumerations
  //////////////////////////////

  // Constant index for the digest datapath
  typedef enum logic [1:0] {
    FlashDataSel = 2'd0,
    FlashAddrSel = 2'd1,
    SramSel      = 2'd2
  } digest_sel_e;

  // Datapath commands
  typedef enum logic [1:0] {
    LoadShadow     = 2'd0,
    Digest         = 2'd1,
    DigestInit     = 2'd2,
    DigestFinalize = 2'd3
  } scrmbl_cmd_e;

  // Controller states
  typedef enum logic [3:0] {
    ResetSt, IdleSt, DigClrSt, DigLoadSt, FetchEntropySt, DigEntropySt,
    DigFinSt, DigWaitSt, FetchNonceSt, FinishSt, ErrorSt
  } kdi_state_e;

endpackage

// ==== rtl/kdi_req_arbiter.sv ====
//////////////////////////////
// Round-robin requester arbiter with per-requester digest configuration
//////////////////////////////

`timescale 1ns/1ps
`include "kdi_params.svh"

module kdi_req_arbiter (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  kdi_pkg::req_vec_t           req_i,
  input  kdi_pkg::seed_t              flash_data_seed_i,
  input  kdi_pkg::seed_t              flash_addr_seed_i,
  input  logic [`KDI_SRAM_SEED_W-1:0] sram_seed_i,
  input  logic                        req_done_i,
  output kdi_pkg::req_vec_t           ack_o,
  output logic                        req_valid_o,
  output kdi_pkg::seed_t              seed_o,
  output logic                        ingest_entropy_o,
  output logic                        nonce_last_o,
  output kdi_pkg::digest_sel_e        digest_sel_o
);
  import kdi_pkg::*;

  logic [1:0] ptr_q;
  logic [1:0] idx_q, idx_d, idx_next;
  logic       lock_q;
  logic       any_req;

  // Lowest pending index at or after the pointer, wrapping around
  always_comb begin : p_pick
    logic [1:0] cand;
    idx_d   = idx_q;
    any_req = 1'b0;
    cand    = ptr_q;
    for (int i = 0; i < `KDI_NUM_REQ; i++) begin
      if (!any_req && req_i[cand]) begin
        idx_d   = cand;
        any_req = 1'b1;
      end
      cand = (cand == 2'(`KDI_NUM_REQ - 1)) ? 2'd0 : cand + 2'd1;
    end
  end

  // Pointer moves past the requester just served
  assign idx_next = (idx_q == 2'(`KDI_NUM_REQ - 1)) ? 2'd0 : idx_q + 2'd1;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lock
    if (!rst_ni) begin
      ptr_q  <= 2'd0;
      idx_q  <= 2'd0;
      lock_q <= 1'b0;
    end else if (lock_q) begin
      // Release on completion
      if (req_done_i) begin
        lock_q <= 1'b0;
        ptr_q  <= idx_next;
      end
    end else if (any_req) begin
      lock_q <= 1'b1;
      idx_q  <= idx_d;
    end
  end

  assign req_valid_o = lock_q;

  // One-cycle ack to the locked requester
  always_comb begin : p_ack
    ack_o = '0;
    if (lock_q && req_done_i) begin
      ack_o[idx_q] = 1'b1;
    end
  end

  //////////////////////////////
  // Configuration of the granted requester
  //////////////////////////////

  always_comb begin : p_cfg
    // Flash data key by default
    ingest_entropy_o = 1'b0;
    nonce_last_o     = 1'b1;
    digest_sel_o     = FlashDataSel;
    seed_o           = flash_data_seed_i;
    case (idx_q)
      2'd1: begin
        // Flash address key takes a single nonce word
        nonce_last_o = 1'b0;
        digest_sel_o = FlashAddrSel;
        seed_o       = flash_addr_seed_i;
      end
      2'd2: begin
        ingest_entropy_o = 1'b1;
        digest_sel_o     = SramSel;
        // Same SRAM seed for both key halves
        seed_o           = {sram_seed_i, sram_seed_i};
      end
      default: begin
        ingest_entropy_o = 1'b0;
      end
    endcase
  end

endmodule

// ==== rtl/kdi_top.sv ====
//////////////////////////////
// Key derivation unit top level
//////////////////////////////

`timescale 1ns/1ps
`include "kdi_params.svh"

module kdi_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        kdi_en_i,
  input  logic                        escalate_en_i,
  input  kdi_pkg::req_vec_t           req_i,
  output kdi_pkg::req_vec_t           ack_o,
  input  logic                        seed_valid_i,
  input  kdi_pkg::seed_t              flash_data_seed_i,
  input  kdi_pkg::seed_t              flash_addr_seed_i,
  input  logic [`KDI_SRAM_SEED_W-1:0] sram_seed_i,
  output logic                        edn_req_o,
  input  logic                        edn_ack_i,
  input  kdi_pkg::block_t             edn_data_i,
  output kdi_pkg::key_t               key_o,
  output kdi_pkg::nonce_t             nonce_o,
  output logic                        seed_valid_o,
  output logic                        fsm_err_o,
  output logic                        scrmbl_mtx_req_o,
  input  logic                        scrmbl_mtx_gnt_i,
  output kdi_pkg::scrmbl_cmd_e        scrmbl_cmd_o,
  output kdi_pkg::digest_sel_e        scrmbl_sel_o,
  output kdi_pkg::block_t             scrmbl_data_o,
  input  kdi_pkg::block_t             scrmbl_data_i,
  output logic                        scrmbl_valid_o,
  input  logic                        scrmbl_ready_i,
  input  logic                        scrmbl_valid_i
);
  import kdi_pkg::*;

  // Arbiter to controller and registers
  logic        req_valid, ingest_entropy, nonce_last, req_done;
  digest_sel_e digest_sel;
  seed_t       seed;
  // Controller strobes into the register block
  logic        seed_cnt_clr, seed_cnt_en, ent_cnt_clr, ent_cnt_en;
  logic        key_wr, nonce_wr, seed_valid_wr, data_sel;
  blk_cnt_t    seed_cnt, ent_cnt;

  kdi_req_arbiter u_arb (
    .clk_i, .rst_ni, .req_i, .flash_data_seed_i, .flash_addr_seed_i, .sram_seed_i,
    .req_done_i       (req_done),
    .ack_o,
    .req_valid_o      (req_valid),
    .seed_o           (seed),
    .ingest_entropy_o (ingest_entropy),
    .nonce_last_o     (nonce_last),
    .digest_sel_o     (digest_sel)
  );

  kdi_key_regs u_regs (
    .clk_i, .rst_ni, .seed_valid_i, .edn_data_i, .scrmbl_data_i,
    .seed_i (seed), .seed_cnt_clr_i (seed_cnt_clr), .seed_cnt_en_i (seed_cnt_en),
    .ent_cnt_clr_i (ent_cnt_clr), .ent_cnt_en_i (ent_cnt_en), .key_wr_i (key_wr),
    .nonce_wr_i (nonce_wr), .seed_valid_wr_i (seed_valid_wr), .data_sel_i (data_sel),
    .seed_cnt_o (seed_cnt), .ent_cnt_o (ent_cnt),
    .scrmbl_data_o, .key_o, .nonce_o, .seed_valid_o
  );

  kdi_ctrl_fsm u_fsm (
    .clk_i, .rst_ni, .kdi_en_i, .escalate_en_i, .edn_ack_i,
    .scrmbl_mtx_gnt_i, .scrmbl_ready_i, .scrmbl_valid_i,
    .req_valid_i (req_valid), .ingest_entropy_i (ingest_entropy),
    .nonce_last_i (nonce_last), .digest_sel_i (digest_sel),
    .seed_cnt_i (seed_cnt), .ent_cnt_i (ent_cnt),
    .seed_cnt_clr_o (seed_cnt_clr), .seed_cnt_en_o (seed_cnt_en),
    .ent_cnt_clr_o (ent_cnt_clr), .ent_cnt_en_o (ent_cnt_en), .key_wr_o (key_wr),
    .nonce_wr_o (nonce_wr), .seed_valid_wr_o (seed_valid_wr), .data_sel_o (data_sel),
    .req_done_o (req_done),
    .edn_req_o, .scrmbl_mtx_req_o, .scrmbl_cmd_o, .scrmbl_sel_o, .scrmbl_valid_o,
    .fsm_err_o
  );

endmodule
